// ==== Makefile ====
VERILATOR       = verilator
VERILATOR_FLAGS = --binary --timing --assert -Wno-fatal
TOP_MODULE      = valid_ready_fifo_tb
FILE_LIST       = filelist.f
BUILD_DIR       = obj_dir
PASS_MESSAGE    = Test completed successfully

SOURCES    = $(shell grep -v '^+' $(FILE_LIST))
SIM_BINARY = $(BUILD_DIR)/V$(TOP_MODULE)

.PHONY: all build run clean

all: run

build: $(SIM_BINARY)

# Rebuilt only when a source or the file list changes
$(SIM_BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP_MODULE) \
		-Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BINARY)
	@output="$$(./$(SIM_BINARY))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
src/fifo_pkg.sv
src/fifo_memory_if.sv
src/fifo_controller.sv
src/simple_dual_port_ram.sv
src/valid_ready_fifo.sv
verification/valid_ready_fifo_assert.sv
verification/valid_ready_fifo_tb.sv

// ==== src/fifo_controller.sv ====
`timescale 1ns/10ps

// Pointer and occupancy bookkeeping for the FIFO
// Turns accepted writes and reads into RAM accesses
module fifo_controller import fifo_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // Write side, already qualified by the handshake
  input  logic                  write_enable,
  input  logic [fifo_width-1:0] write_data,
  // Read side, already qualified by the handshake
  input  logic                  read_enable,
  output logic [fifo_width-1:0] read_data,
  // Status flags, registered
  output logic                  full,
  output logic                  empty,
  // Storage access
  fifo_memory_if.controller     memory
);

  // Pointers into the RAM
  logic [fifo_address_width-1:0] write_pointer;
  logic [fifo_address_width-1:0] read_pointer;

  // Number of stored words
  logic [fifo_count_width-1:0]   count;
  logic [fifo_count_width-1:0]   count_next;

  // Transfers that really happen this cycle
  logic                          write_accept;
  logic                          read_accept;

  // Next pointer value with wrap at the last entry
  // Depth need not be a power of two
  function automatic logic [fifo_address_width-1:0] advance_pointer(
    input logic [fifo_address_width-1:0] pointer
  );
    if (pointer == fifo_last_address) begin
      return '0;
    end
    return pointer + 1'b1;
  endfunction

  // No write into a full queue, no read from an empty one
  assign write_accept = write_enable && !full;
  assign read_accept  = read_enable && !empty;

  // Occupancy for the next cycle
  always_comb begin
    case ({write_accept, read_accept})
      // Write only
      2'b10:   count_next = count + 1'b1;
      // Read only
      2'b01:   count_next = count - 1'b1;
      // Idle, or write and read together
      default: count_next = count;
    endcase
  end

  // Write pointer
  always_ff @(posedge clock) begin
    if (reset) begin
      write_pointer <= '0;
    end else if (write_accept) begin
      write_pointer <= advance_pointer(write_pointer);
    end
  end

  // Read pointer
  // Moves on the consuming edge, next word shows the cycle after
  always_ff @(posedge clock) begin
    if (reset) begin
      read_pointer <= '0;
    end else if (read_accept) begin
      read_pointer <= advance_pointer(read_pointer);
    end
  end

  // Counter and flags
  // Flags come from the next count so they line up with the counter
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      count <= count_next;
      full  <= (count_next == fifo_full_count);
      empty <= (count_next == '0);
    end
  end

  // RAM write port follows the write pointer
  assign memory.write_enable  = write_accept;
  assign memory.write_address = write_pointer;
  assign memory.write_data    = write_data;

  // RAM read port follows the read pointer
  assign memory.read_enable   = read_accept;
  assign memory.read_address  = read_pointer;

  // Head word straight from the RAM
  assign read_data = memory.read_data;

endmodule

// ==== src/fifo_memory_if.sv ====
`timescale 1ns/10ps

// Bundle between the FIFO controller and its storage RAM
// One write port and one read port, both addressed by pointers
interface fifo_memory_if import fifo_pkg::*; ();

  // Write port
  // Strobe for one word on the next rising edge
  logic                          write_enable;
  // Entry taking the word
  logic [fifo_address_width-1:0] write_address;
  // Word to store
  logic [fifo_width-1:0]         write_data;

  // Read port
  // Marks that the head word is consumed this cycle
  logic                          read_enable;
  // Entry presented on read_data
  logic [fifo_address_width-1:0] read_address;
  // Contents of the entry at read_address, no register
  logic [fifo_width-1:0]         read_data;

  // Controller side
  // Drives strobes, addresses and write data
  modport controller (
    output write_enable,
    output write_address,
    output write_data,
    output read_enable,
    output read_address,
    input  read_data
  );

  // Storage side
  // Only the read data comes back
  modport memory (
    input  write_enable,
    input  write_address,
    input  write_data,
    input  read_enable,
    input  read_address,
    output read_data
  );

endinterface

// ==== src/fifo_pkg.sv ====
// Shared sizing for the valid-ready FIFO
package fifo_pkg;

  // Width of one queued word
  localparam int fifo_width = 8;

  // Number of storage entries in the RAM
  localparam int fifo_depth = 4;

  // Bits for one pointer or RAM address
  // Ceiling log2 of the depth
  localparam int fifo_address_width = $clog2(fifo_depth);

  // Bits for the occupancy counter
  // Must hold every value from 0 to fifo_depth inclusive
  localparam int fifo_count_width = $clog2(fifo_depth + 1);

  // Pointer value of the last entry, used for wrapping
  localparam logic [fifo_address_width-1:0] fifo_last_address =
    fifo_address_width'(fifo_depth - 1);

  // Counter value that means every entry is taken
  localparam logic [fifo_count_width-1:0] fifo_full_count =
    fifo_count_width'(fifo_depth);

endpackage

// ==== src/simple_dual_port_ram.sv ====
`timescale 1ns/10ps

// Storage for the FIFO
// One synchronous write port and one combinational read port
module simple_dual_port_ram import fifo_pkg::*; (
  input  logic          clock,
  fifo_memory_if.memory memory
);

  // Word array
  logic [fifo_width-1:0] storage [fifo_depth];

  // Write port
  always_ff @(posedge clock) begin
    if (memory.write_enable) begin
      storage[memory.write_address] <= memory.write_data;
    end
  end

  // Read port
  // No register, the word follows the address in the same cycle
  assign memory.read_data = storage[memory.read_address];

endmodule

// ==== src/valid_ready_fifo.sv ====
`timescale 1ns/10ps

// Synchronous FIFO with valid-ready flow control
// Write handshake on one side, read handshake on the other
module valid_ready_fifo import fifo_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // Status
  output logic                  full,
  output logic                  empty,
  // Write side
  input  logic [fifo_width-1:0] write_data,
  input  logic                  write_valid,
  output logic                  write_ready,
  // Read side
  output logic [fifo_width-1:0] read_data,
  output logic                  read_valid,
  input  logic                  read_ready
);

  // Transfers on this edge
  logic write_enable;
  logic read_enable;

  // Handshakes
  // A word moves when both sides agree
  assign write_enable = write_valid && write_ready;
  assign read_enable  = read_valid && read_ready;

  // Ready and valid straight from the registered flags
  assign write_ready  = !full;
  assign read_valid   = !empty;

  // Link between controller and RAM
  fifo_memory_if memory_bus ();

  // Pointers, count and flags
  fifo_controller controller (
    .clock        (clock),
    .reset        (reset),
    .write_enable (write_enable),
    .write_data   (write_data),
    .read_enable  (read_enable),
    .read_data    (read_data),
    .full         (full),
    .empty        (empty),
    .memory       (memory_bus.controller)
  );

  // Storage
  // Head word shows on read_data with no extra cycle
  simple_dual_port_ram memory (
    .clock  (clock),
    .memory (memory_bus.memory)
  );

endmodule

// ==== verification/valid_ready_fifo_assert.sv ====
`timescale 1ns/10ps

// Flow-control and flag rules of the valid-ready FIFO
// Bound into every valid_ready_fifo instance
module valid_ready_fifo_assert import fifo_pkg::*; (
  input logic                  clock,
  input logic                  reset,
  input logic                  full,
  input logic                  empty,
  input logic [fifo_width-1:0] write_data,
  input logic                  write_valid,
  input logic                  write_ready,
  input logic [fifo_width-1:0] read_data,
  input logic                  read_valid,
  input logic                  read_ready
);

  logic write_transfer;
  logic read_transfer;

  assign write_transfer = write_valid && write_ready;
  assign read_transfer  = read_valid && read_ready;

  // Synchronous reset leaves an empty queue
  reset_clears_flags: assert property (@(posedge clock) reset |=> empty && !full)
    else $error("Flags not cleared by reset");

  // A read always frees an entry
  read_leaves_room: assert property (@(posedge clock) disable iff (reset)
    read_transfer |=> !full)
    else $error("Queue full right after a read");

  // Only a write can clear empty
  empty_held_without_write: assert property (@(posedge clock) disable iff (reset)
    empty && !write_transfer |=> empty)
    else $error("Empty dropped without a write");

  // Stalled consumer sees the same head word
  head_held_under_stall: assert property (@(posedge clock) disable iff (reset)
    read_valid && !read_ready |=> read_valid && $stable(read_data))
    else $error("Head word lost or changed under back-pressure");

  // Write into an empty queue readable one cycle later
  empty_write_visible: assert property (@(posedge clock) disable iff (reset)
    empty && write_transfer |=> read_valid && (read_data == $past(write_data)))
    else $error("Word written into empty queue not on read_data");

  // Only a read can clear full
  full_held_without_read: assert property (@(posedge clock) disable iff (reset)
    full && !read_transfer |=> full)
    else $error("Full dropped without a read");

  write_leaves_data: assert property (@(posedge clock) disable iff (reset)
    write_transfer |=> !empty)
    else $error("Queue empty right after a write");

endmodule

bind valid_ready_fifo valid_ready_fifo_assert flow_checks (
  .clock       (clock),
  .reset       (reset),
  .full        (full),
  .empty       (empty),
  .write_data  (write_data),
  .write_valid (write_valid),
  .write_ready (write_ready),
  .read_data   (read_data),
  .read_valid  (read_valid),
  .read_ready  (read_ready)
);

// ==== verification/valid_ready_fifo_tb.sv ====
`timescale 1ns/10ps

// Directed and random traffic for the valid-ready FIFO
// Reference queue holds every accepted word, oldest first
module valid_ready_fifo_tb import fifo_pkg::*;;

  localparam int clock_period = 10;
  localparam int drive_delay  = 1;
  localparam int reset_cycles = 8;
  localparam int random_cycles = 300;
  // Directed part and drain take well under 100 cycles, so about twice the run
  localparam int cycle_limit  = 800;

  logic                  clock;
  logic                  reset;
  logic [fifo_width-1:0] write_data;
  logic                  write_valid;
  logic                  write_ready;
  logic [fifo_width-1:0] read_data;
  logic                  read_valid;
  logic                  read_ready;
  logic                  full;
  logic                  empty;

  // Accepted words not yet read back
  logic [fifo_width-1:0] expected_words [$];

  string       test_name;
  int          mismatch_count;
  int          failure_count;
  int          cycle_count;
  int          write_count;
  int          read_count;
  int          seed;
  logic [31:0] random_value;
  logic        write_taken;

  valid_ready_fifo dut_i (
    .clock       (clock),
    .reset       (reset),
    .full        (full),
    .empty       (empty),
    .write_data  (write_data),
    .write_valid (write_valid),
    .write_ready (write_ready),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .read_ready  (read_ready)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // Run limit
  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_word(input string signal_name, input logic [fifo_width-1:0] expected,
                            input logic [fifo_width-1:0] actual);
    assert (actual === expected) else begin
      mismatch_count++;
      $display("Mismatch in %s, %s: expected %02h, actual %02h",
               test_name, signal_name, expected, actual);
    end
  endtask

  task automatic check_flag(input string signal_name, input logic expected, input logic actual);
    assert (actual === expected) else begin
      mismatch_count++;
      $display("Mismatch in %s, %s: expected %b, actual %b",
               test_name, signal_name, expected, actual);
    end
  endtask

  // Transfers are decided by the values held through the second half of the cycle
  always @(negedge clock) begin
    if (!reset) begin
      // Read first, a word written on the same edge sits behind the head
      if (read_valid && read_ready) begin
        read_count++;
        if (expected_words.size() == 0) begin
          failure_count++;
          $display("In %s a word was read although none had been written", test_name);
        end else begin
          check_word("read_data", expected_words.pop_front(), read_data);
        end
      end
      if (write_valid && write_ready) begin
        write_count++;
        expected_words.push_back(write_data);
      end
    end
  end

  // Inputs change a short delay after the rising edge
  task automatic advance_cycle();
    @(posedge clock);
    #drive_delay;
  endtask

  // Offer one word, hold it until taken
  task automatic write_word(input logic [fifo_width-1:0] word);
    logic taken;
    write_data  = word;
    write_valid = 1'b1;
    do begin
      @(negedge clock);
      taken = write_ready;
      advance_cycle();
    end while (!taken);
    write_valid = 1'b0;
  endtask

  // Take one word, the scoreboard checks its value
  task automatic read_word();
    logic taken;
    read_ready = 1'b1;
    do begin
      @(negedge clock);
      taken = read_valid;
      advance_cycle();
    end while (!taken);
    read_ready = 1'b0;
  endtask

  // Flags and the handshake outputs derived from them
  task automatic check_status(input logic expect_empty, input logic expect_full);
    @(negedge clock);
    check_flag("empty", expect_empty, empty);
    check_flag("full", expect_full, full);
    check_flag("write_ready", !expect_full, write_ready);
    check_flag("read_valid", !expect_empty, read_valid);
    advance_cycle();
  endtask

  task automatic check_queue_drained();
    if (expected_words.size() != 0) begin
      failure_count++;
      $display("In %s %0d accepted words never came out", test_name, expected_words.size());
    end
  endtask

  initial begin
    seed           = 32'h240d_561a;
    mismatch_count = 0;
    failure_count  = 0;
    cycle_count    = 0;
    write_count    = 0;
    read_count     = 0;
    write_taken    = 1'b0;
    reset          = 1'b1;
    write_data     = '0;
    write_valid    = 1'b0;
    read_ready     = 1'b0;
    test_name      = "reset";
    repeat (reset_cycles) @(posedge clock);
    #drive_delay;
    reset = 1'b0;
    check_status(1'b1, 1'b0);

    // One word shows up the cycle after its write edge
    test_name = "single word";
    write_word(8'h5a);
    @(negedge clock);
    check_flag("read_valid", 1'b1, read_valid);
    check_word("read_data", 8'h5a, read_data);
    advance_cycle();
    read_word();
    check_status(1'b1, 1'b0);

    // Consumer stalled, queue fills up
    test_name = "fill to full";
    for (int i = 0; i < fifo_depth; i++) begin
      write_word(8'hc0 + i[7:0]);
    end
    check_status(1'b0, 1'b1);
    // Fifth word offered and refused
    write_data  = 8'hee;
    write_valid = 1'b1;
    repeat (3) begin
      @(negedge clock);
      check_flag("write_ready", 1'b0, write_ready);
      advance_cycle();
    end
    write_valid = 1'b0;

    // Words come back in write order
    test_name = "drain";
    repeat (fifo_depth) read_word();
    check_status(1'b1, 1'b0);
    check_queue_drained();

    // Partial count, one write and one read on the same edge
    test_name = "write and read together";
    write_word(8'h31);
    write_word(8'h32);
    write_data  = 8'h33;
    write_valid = 1'b1;
    read_ready  = 1'b1;
    @(negedge clock);
    check_flag("write_ready", 1'b1, write_ready);
    check_flag("read_valid", 1'b1, read_valid);
    advance_cycle();
    write_valid = 1'b0;
    read_ready  = 1'b0;
    check_status(1'b0, 1'b0);
    repeat (2) read_word();
    check_status(1'b1, 1'b0);

    // Random offers, the producer keeps a word until it is taken
    test_name = "random traffic";
    repeat (random_cycles) begin
      random_value = $random(seed);
      if (write_taken) begin
        write_valid = 1'b0;
      end
      if (!write_valid && random_value[0]) begin
        write_valid = 1'b1;
        write_data  = random_value[15:8];
      end
      read_ready = random_value[1];
      @(negedge clock);
      write_taken = write_valid && write_ready;
      advance_cycle();
    end
    write_valid = 1'b0;
    read_ready  = 1'b1;
    while (read_valid) advance_cycle();
    read_ready = 1'b0;
    check_queue_drained();

    $display("Errors: %0d mismatches, %0d other failures (%0d words written, %0d read)",
             mismatch_count, failure_count, write_count, read_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
